/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f vectorCommitTop.f \
		--top-module vectorCommitTb -Mdir obj_dir -o simv
	./obj_dir/simv | tee $(LOG)
	@grep -q "PASS: all tests" $(LOG) || (echo "Simulation failed"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

/* hw/commitAggregator.sv */
`timescale 1ns/1ps
`include "vector_macros.svh"

module commitAggregator #(
	parameter int BUFF_SIZE = `BUFF_SIZE
) (
	input	logic					clock,
	input	logic					reset,
	input	logic					issueReq,
	input	vectorPkg::issueNo_t	issueNo,
	input	vectorPkg::laneMask_t	laneMask,
	input	vectorPkg::laneMask_t	laneCommitReq,				// Pulse per lane
	input	vectorPkg::issueNo_t	laneCommitNo	[`NUM_LANES],
	input	logic					commitGrant,
	output	logic					commitValid,				// Held until granted
	output	vectorPkg::issueNo_t	commitNo,
	output	logic					full
);
	import vectorPkg::*;

	localparam int PTR_BITS = $clog2(BUFF_SIZE);

	commitEntry_t			entries	[BUFF_SIZE];
	logic [`NUM_LANES-1:0]	matched	[BUFF_SIZE];
	logic [PTR_BITS-1:0]	wAddr;
	logic [PTR_BITS-1:0]	rAddr;
	logic					we;
	logic					re;
	logic					empty;
	logic					headDone;

	////////////////////////////////////////
	// Oldest entry release
	////////////////////////////////////////

	// Head is done once every enabled lane has reported
	assign headDone = entries[rAddr].valid
		& (entries[rAddr].committed == entries[rAddr].enable);

	assign commitValid	= ~empty & headDone;
	assign commitNo		= entries[rAddr].issueNo;

	assign we = issueReq;				// One entry per issued instruction
	assign re = commitValid & commitGrant;

	////////////////////////////////////////
	// Lane commit matching
	////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < BUFF_SIZE; i++) begin
			for (int j = 0; j < `NUM_LANES; j++) begin
				matched[i][j] = entries[i].valid & entries[i].enable[j]
					& laneCommitReq[j] & (laneCommitNo[j] == entries[i].issueNo);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < BUFF_SIZE; i++) begin
				entries[i] <= '0;
			end
		end else begin
			for (int i = 0; i < BUFF_SIZE; i++) begin
				entries[i].committed <= entries[i].committed | matched[i];
			end

			if (re) begin
				entries[rAddr].valid <= 1'b0;	// Granted, slot is free
			end

			if (we) begin
				entries[wAddr].valid		<= 1'b1;
				entries[wAddr].enable		<= laneMask;
				entries[wAddr].committed	<= '0;
				entries[wAddr].issueNo		<= issueNo;
			end
		end
	end

	ringBuffCtrl #(
		.NUM_ENTRY	(BUFF_SIZE)
	) ringCtrl (
		.clock	(clock),
		.reset	(reset),
		.we		(we),
		.re		(re),
		.wAddr	(wAddr),
		.rAddr	(rAddr),
		.full	(full),
		.empty	(empty)
	);

endmodule

/* hw/issueDecoder.sv */
`timescale 1ns/1ps
`include "vector_macros.svh"

module issueDecoder (
	input	logic					clock,
	input	logic					reset,
	input	logic					instrValid,		// One strobe per instruction
	input	vectorPkg::instrWord_t	instrWord,
	input	logic					stallIn,		// Any full flag downstream
	output	logic					issueReq,
	output	vectorPkg::issueNo_t	issueNo,
	output	vectorPkg::laneMask_t	laneMask,
	output	vectorPkg::latency_t	latency,
	output	logic					stall
);
	import vectorPkg::*;

	localparam laneMask_t ALL_LANES = {`NUM_LANES{1'b1}};

	logic		isBroadcast;
	logic		noMask;
	issueNo_t	issueCount;

	// Format bit is shared by both views
	assign isBroadcast	= instrWord.broadcastForm.format;
	assign noMask		= (instrWord.vectorForm.mask == '0);

	////////////////////////////////////////
	// Decode
	////////////////////////////////////////

	always_comb begin
		if (isBroadcast) begin
			laneMask	= ALL_LANES;
			latency		= instrWord.broadcastForm.latency;
		end else begin
			laneMask	= noMask ? ALL_LANES : instrWord.vectorForm.mask;
			latency		= latency_t'(instrWord.vectorForm.latency);	// Zero-extend
		end
	end

	// Strobes during stall are dropped
	assign issueReq	= instrValid & ~stallIn;
	assign issueNo	= issueCount;
	assign stall	= stallIn;

	////////////////////////////////////////
	// Issue numbering
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			issueCount <= '0;
		end else if (issueReq) begin
			issueCount <= issueCount + 1'b1;	// Wraps past the top
		end
	end

endmodule

/* hw/laneUnit.sv */
`timescale 1ns/1ps
`include "vector_macros.svh"

module laneUnit #(
	parameter int LANE_INDEX = 0
) (
	input	logic					clock,
	input	logic					reset,
	input	logic					issueReq,
	input	logic					laneSel,		// This lane's mask bit
	input	vectorPkg::issueNo_t	issueNo,
	input	vectorPkg::latency_t	latency,
	output	logic					commitReq,		// One-cycle pulse
	output	vectorPkg::issueNo_t	commitNo,
	output	logic					full
);
	import vectorPkg::*;

	localparam int PTR_BITS = (`LANE_DEPTH > 1) ? $clog2(`LANE_DEPTH) : 1;
	localparam int OCC_BITS = $clog2(`LANE_DEPTH + 1);

	issueNo_t				queueNo		[`LANE_DEPTH];
	latency_t				queueLat	[`LANE_DEPTH];
	logic [PTR_BITS-1:0]	headPtr;
	logic [PTR_BITS-1:0]	tailPtr;
	logic [OCC_BITS-1:0]	occupancy;
	logic					active;			// Head operation is counting
	logic [8:0]				countdown;		// Room for latency plus index
	logic					push;
	logic					pop;
	logic					load;
	latency_t				loadLat;

	function automatic logic [PTR_BITS-1:0] nextPtr(input logic [PTR_BITS-1:0] ptr);
		return (ptr == PTR_BITS'(`LANE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign push = issueReq & laneSel;
	assign pop	= active & (countdown == '0);
	assign load = ~active & ((occupancy != '0) | push);

	// An idle empty lane starts on the incoming operation directly
	assign loadLat = (occupancy != '0) ? queueLat[headPtr] : latency;

	assign full = (occupancy == OCC_BITS'(`LANE_DEPTH));

	////////////////////////////////////////
	// Queue storage
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (push) begin
			queueNo[tailPtr]	<= issueNo;
			queueLat[tailPtr]	<= latency;
		end
		if (pop) begin
			commitNo <= queueNo[headPtr];
		end
	end

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			headPtr		<= '0;
			tailPtr		<= '0;
			occupancy	<= '0;
			active		<= 1'b0;
			countdown	<= '0;
			commitReq	<= 1'b0;
		end else begin
			commitReq <= pop;	// Pulse, cleared next edge

			if (push) tailPtr <= nextPtr(tailPtr);
			if (pop) headPtr <= nextPtr(headPtr);

			case ({push, pop})
				2'b10:		occupancy <= occupancy + 1'b1;
				2'b01:		occupancy <= occupancy - 1'b1;
				default:	occupancy <= occupancy;
			endcase

			// Next countdown waits for the pulse to end
			if (load) begin
				active		<= 1'b1;
				countdown	<= {1'b0, loadLat} + 9'(LANE_INDEX);
			end else if (pop) begin
				active		<= 1'b0;
			end else if (active) begin
				countdown	<= countdown - 1'b1;
			end
		end
	end

endmodule

/* hw/ringBuffCtrl.sv */
`timescale 1ns/1ps

module ringBuffCtrl #(
	parameter int NUM_ENTRY = 4
) (
	input	logic							clock,
	input	logic							reset,
	input	logic							we,
	input	logic							re,
	output	logic [$clog2(NUM_ENTRY)-1:0]	wAddr,
	output	logic [$clog2(NUM_ENTRY)-1:0]	rAddr,
	output	logic							full,
	output	logic							empty
);

	localparam int PTR_BITS = $clog2(NUM_ENTRY);
	localparam int CNT_BITS = $clog2(NUM_ENTRY + 1);
	localparam logic [PTR_BITS-1:0] LAST = PTR_BITS'(NUM_ENTRY - 1);

	logic [CNT_BITS-1:0]	count;
	logic					doWrite;
	logic					doRead;

	assign doWrite	= we & ~full;
	assign doRead	= re & ~empty;

	assign full		= (count == CNT_BITS'(NUM_ENTRY));
	assign empty	= (count == '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			wAddr	<= '0;
			rAddr	<= '0;
			count	<= '0;
		end else begin
			if (doWrite) wAddr <= (wAddr == LAST) ? '0 : wAddr + 1'b1;
			if (doRead) rAddr <= (rAddr == LAST) ? '0 : rAddr + 1'b1;

			// Write and read together leave the count alone
			if (doWrite & ~doRead) count <= count + 1'b1;
			else if (doRead & ~doWrite) count <= count - 1'b1;
		end
	end

endmodule

/* hw/vectorCommitTop.sv */
`timescale 1ns/1ps
`include "vector_macros.svh"

module vectorCommitTop (
	input	logic					clock,
	input	logic					reset,
	input	logic					instrValid,
	input	vectorPkg::instrWord_t	instrWord,
	input	logic					commitGrant,
	output	logic					commitValid,
	output	vectorPkg::issueNo_t	commitNo,
	output	logic					stall
);
	import vectorPkg::*;

	logic					issueReq;
	issueNo_t				issueNo;
	laneMask_t				laneMask;
	latency_t				latency;
	laneMask_t				laneCommitReq;
	issueNo_t				laneCommitNo	[`NUM_LANES];
	logic [`NUM_LANES:0]	fullFlags;		// Top bit is the aggregator
	logic					stallIn;

	assign stallIn = |fullFlags;

	issueDecoder decoder (
		.clock		(clock),
		.reset		(reset),
		.instrValid	(instrValid),
		.instrWord	(instrWord),
		.stallIn	(stallIn),
		.issueReq	(issueReq),
		.issueNo	(issueNo),
		.laneMask	(laneMask),
		.latency	(latency),
		.stall		(stall)
	);

	////////////////////////////////////////
	// Lanes
	////////////////////////////////////////

	for (genvar i = 0; i < `NUM_LANES; i++) begin : laneGen
		laneUnit #(
			.LANE_INDEX	(i)
		) lane (
			.clock		(clock),
			.reset		(reset),
			.issueReq	(issueReq),
			.laneSel	(laneMask[i]),
			.issueNo	(issueNo),
			.latency	(latency),
			.commitReq	(laneCommitReq[i]),
			.commitNo	(laneCommitNo[i]),
			.full		(fullFlags[i])
		);
	end

	commitAggregator #(
		.BUFF_SIZE	(`BUFF_SIZE)
	) aggregator (
		.clock			(clock),
		.reset			(reset),
		.issueReq		(issueReq),
		.issueNo		(issueNo),
		.laneMask		(laneMask),
		.laneCommitReq	(laneCommitReq),
		.laneCommitNo	(laneCommitNo),
		.commitGrant	(commitGrant),
		.commitValid	(commitValid),
		.commitNo		(commitNo),
		.full			(fullFlags[`NUM_LANES])
	);

endmodule

/* hw/vectorPkg.sv */
`include "vector_macros.svh"

package vectorPkg;

	typedef logic [`ISSUE_BITS-1:0]	issueNo_t;	// Wraps to zero
	typedef logic [`NUM_LANES-1:0]	laneMask_t;	// One bit per lane
	typedef logic [7:0]				latency_t;	// Base latency in cycles

	////////////////////////////////////////
	// Instruction word formats
	////////////////////////////////////////

	// Format 0, per-lane mask with short latency
	typedef struct packed {
		logic			format;
		logic [6:0]		tag;		// Ignored by the engine
		logic [3:0]		latency;
		laneMask_t		mask;		// Zero selects all lanes
	} vectorInstr_t;

	// Format 1, all lanes with long latency
	typedef struct packed {
		logic			format;
		logic [6:0]		unused;
		latency_t		latency;
	} broadcastInstr_t;

	typedef union packed {
		vectorInstr_t		vectorForm;
		broadcastInstr_t	broadcastForm;
	} instrWord_t;

	// One slot of the commit buffer
	typedef struct packed {
		logic			valid;
		laneMask_t		enable;		// Lanes selected at issue
		laneMask_t		committed;	// Lanes done so far
		issueNo_t		issueNo;
	} commitEntry_t;

endpackage

/* hw/vector_macros.svh */
`ifndef VECTOR_MACROS_SVH
`define VECTOR_MACROS_SVH

////////////////////////////////////////
// Engine sizes
////////////////////////////////////////

// Lane units behind the issue decoder
`define NUM_LANES	4

// Commit buffer entries, bounds the instructions in flight
`define BUFF_SIZE	4

// Issue number width, wraps at 2**ISSUE_BITS
`define ISSUE_BITS	4

// Pending operations per lane
`define LANE_DEPTH	2

`endif

/* test/vectorCommitTb.sv */
`timescale 1ns/1ps
`include "vector_macros.svh"

module vectorCommitTb;
	import vectorPkg::*;

	localparam int DRAIN_LIMIT = 2000;	// Cycles allowed for the model queue to empty
	localparam int WAIT_LIMIT = 300;

	logic		clock;
	logic		reset;
	logic		instrValid;
	instrWord_t	instrWord;
	logic		commitGrant;
	logic		commitValid;
	issueNo_t	commitNo;
	logic		stall;

	logic [31:0]	lfsrState;
	int				grantMode;		// 0 low, 1 high, 2 random
	issueNo_t		expectQ[$];		// Issue numbers in acceptance order
	issueNo_t		nextIssue;
	int				commitCount;
	int				errorCount;
	int				checkCount;
	int				testCount;

	vectorCommitTop UUT (
		.clock			(clock),
		.reset			(reset),
		.instrValid		(instrValid),
		.instrWord		(instrWord),
		.commitGrant	(commitGrant),
		.commitValid	(commitValid),
		.commitNo		(commitNo),
		.stall			(stall)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
		return value;
	endfunction

	// Format 0 word with the mask in the low nibble
	function automatic logic [15:0] vectorWord(input logic [3:0] mask, input logic [3:0] lat,
		input logic [6:0] tag);
		return {1'b0, tag, lat, mask};
	endfunction

	function automatic logic [15:0] broadcastWord(input logic [7:0] lat);
		return {1'b1, 7'b0, lat};
	endfunction

	// Random format 0 word, the mask may be zero
	function automatic logic [15:0] randomVector();
		logic [3:0] mask;
		logic [3:0] lat;
		logic [6:0] tag;
		mask = 4'(randBits(4));
		lat = 4'(randBits(4));
		tag = 7'(randBits(7));
		return vectorWord(mask, lat, tag);
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			$display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			errorCount++;
		end
	endtask

	// One cycle step with inputs changed on the falling edge
	task automatic tick();
		@(negedge clock);
		instrValid = 1'b0;
		case (grantMode)
			0:			commitGrant = 1'b0;
			1:			commitGrant = 1'b1;
			default:	commitGrant = 1'(randBits(1));
		endcase
	endtask

	task automatic issueInstr(input logic [15:0] word);
		int waited;
		waited = 0;
		tick();
		while (stall && waited < WAIT_LIMIT) begin
			tick();
			waited++;
		end
		if (stall) begin
			$display("error: stall stayed high for %0d cycles, instruction not sent", WAIT_LIMIT);
			errorCount++;
		end else begin
			instrValid = 1'b1;
			instrWord = word;
			expectQ.push_back(nextIssue);
			nextIssue = nextIssue + 1'b1;	// Wraps at 16
		end
	endtask

	task automatic waitDrain(input string testName);
		int waited;
		waited = 0;
		while (expectQ.size() != 0 && waited < DRAIN_LIMIT) begin
			tick();
			waited++;
		end
		if (expectQ.size() != 0) begin
			$display("error: %s left %0d instructions uncommitted after %0d cycles",
				testName, expectQ.size(), DRAIN_LIMIT);
			errorCount++;
		end
	endtask

	// Commit monitor sampling between the falling edge and the next rising edge
	initial begin
		forever begin
			@(negedge clock);
			#5;
			if (!reset && commitValid && commitGrant) begin
				commitCount++;
				if (expectQ.size() == 0) begin
					$display("error: commit of issue %0h seen with nothing outstanding", commitNo);
					errorCount++;
				end else begin
					checkValue("commitNo", commitNo, expectQ.pop_front());
				end
			end
		end
	end

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic testBroadcast();
		int startCount;
		startCount = commitCount;
		grantMode = 1;
		issueInstr(broadcastWord(8'(randBits(8))));
		waitDrain("broadcast");
		checkValue("commitCount", commitCount - startCount, 1);
		repeat (10) begin
			tick();
			checkValue("commitValid", commitValid, 0);	// Nothing else outstanding
		end
		testCount++;
		$display("test broadcast done, %0d errors so far", errorCount);
	endtask

	task automatic testMasks();
		int startCount;
		int waited;
		logic [3:0] mask;
		logic [3:0] lat;
		grantMode = 1;
		mask = 4'(randBits(4));
		if (mask == 4'b0) mask = 4'b0101;
		startCount = commitCount;
		issueInstr(vectorWord(mask, 4'(randBits(4)), 7'(randBits(7))));
		waitDrain("masked vector");
		checkValue("commitCount", commitCount - startCount, 1);
		startCount = commitCount;
		lat = 4'(randBits(4));
		issueInstr(vectorWord(4'b0000, lat, 7'(randBits(7))));
		// Lane 3 pulses lat + 4 cycles after the issue edge, commitValid one cycle later
		waited = 0;
		tick();
		while (!commitValid && waited < WAIT_LIMIT) begin
			tick();
			waited++;
		end
		if (!commitValid) begin
			$display("error: zero-mask instruction never raised commitValid");
			errorCount++;
		end else begin
			checkValue("zeroMaskDelay", waited, lat + 5);
		end
		waitDrain("zero-mask vector");
		checkValue("commitCount", commitCount - startCount, 1);
		testCount++;
		$display("test masks done, %0d errors so far", errorCount);
	endtask

	task automatic testBackToBack();
		int startCount;
		startCount = commitCount;
		grantMode = 1;
		issueInstr(vectorWord(4'b1000, 4'hf, 7'h11));	// Slow lane first
		issueInstr(vectorWord(4'b0001, 4'h0, 7'h22));	// Finishes well before it
		repeat (4) begin
			if (randBits(1)) issueInstr(broadcastWord(8'(randBits(5))));
			else issueInstr(randomVector());
		end
		waitDrain("back to back");
		checkValue("commitCount", commitCount - startCount, 6);
		testCount++;
		$display("test back to back done, %0d errors so far", errorCount);
	endtask

	task automatic testBackPressure();
		int waited;
		grantMode = 0;
		repeat (`BUFF_SIZE) issueInstr(randomVector());
		waited = 0;
		tick();
		while (!stall && waited < WAIT_LIMIT) begin
			tick();
			waited++;
		end
		if (!stall) begin
			$display("error: stall never rose with the grant held low");
			errorCount++;
		end else begin
			// Strobe under stall gets no issue number
			instrValid = 1'b1;
			instrWord = broadcastWord(8'h01);
		end
		waited = 0;
		while (!commitValid && waited < WAIT_LIMIT) begin
			tick();
			waited++;
		end
		if (!commitValid) begin
			$display("error: commitValid never rose with the grant held low");
			errorCount++;
		end
		repeat (8) begin
			tick();
			checkValue("commitValid", commitValid, 1);
			checkValue("commitNo", commitNo, expectQ[0]);	// Oldest stays at the head
			checkValue("stall", stall, 1);
		end
		grantMode = 1;
		waitDrain("back pressure");
		testCount++;
		$display("test back pressure done, %0d errors so far", errorCount);
	endtask

	task automatic testRandomStream();
		int startCount;
		startCount = commitCount;
		grantMode = 2;
		repeat (20) begin
			if (randBits(1)) tick();	// Occasional idle cycle
			if (randBits(1)) issueInstr(broadcastWord(8'(randBits(6))));
			else issueInstr(randomVector());
		end
		waitDrain("random stream");
		checkValue("commitCount", commitCount - startCount, 20);
		testCount++;
		$display("test random stream done, %0d errors so far", errorCount);
	endtask

	initial begin
		reset = 1'b1;
		instrValid = 1'b0;
		instrWord = '0;
		commitGrant = 1'b0;
		lfsrState = 32'hdcbb;
		grantMode = 0;
		nextIssue = '0;
		commitCount = 0;
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		repeat (10) @(negedge clock);
		reset = 1'b0;

		testBroadcast();
		testMasks();
		testBackToBack();
		testBackPressure();
		testRandomStream();

		$display("tests %0d, checks %0d, commits %0d, errors %0d",
			testCount, checkCount, commitCount, errorCount);
		if (errorCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* test/vectorCommit_assert.sv */
`timescale 1ns/1ps

module vectorCommitAssert (
	input	logic					clock,
	input	logic					reset,
	input	vectorPkg::issueNo_t	issueNo,
	input	logic					commitValid,
	input	vectorPkg::issueNo_t	commitNo,
	input	logic					commitGrant,
	input	logic					stall
);
	import vectorPkg::*;

	issueNo_t	lastNo;		// Last granted commit
	logic		haveLast;

	always_ff @(posedge clock) begin
		if (reset) begin
			lastNo		<= '0;
			haveLast	<= 1'b0;
		end else if (commitValid && commitGrant) begin
			lastNo		<= commitNo;
			haveLast	<= 1'b1;
		end
	end

	validAfterReset: assert property (@(posedge clock) reset |=> !commitValid)
		else $error("commitValid high right after reset");

	holdWithoutGrant: assert property (@(posedge clock) disable iff (reset)
		commitValid && !commitGrant |=> commitValid && $stable(commitNo))
		else $error("commit report changed while not granted");

	noIssueInStall: assert property (@(posedge clock) disable iff (reset)
		stall |=> $stable(issueNo))
		else $error("instruction numbered during stall");

	commitInOrder: assert property (@(posedge clock) disable iff (reset)
		commitValid && commitGrant && haveLast |-> commitNo == issueNo_t'(lastNo + 1'b1))
		else $error("granted commit number skipped or repeated");

endmodule

bind vectorCommitTop vectorCommitAssert protocolChecks (
	.clock			(clock),
	.reset			(reset),
	.issueNo		(issueNo),
	.commitValid	(commitValid),
	.commitNo		(commitNo),
	.commitGrant	(commitGrant),
	.stall			(stall)
);

/* vectorCommitTop.f */
+incdir+hw
hw/vectorPkg.sv
hw/ringBuffCtrl.sv
hw/issueDecoder.sv
hw/laneUnit.sv
hw/commitAggregator.sv
hw/vectorCommitTop.sv
test/vectorCommit_assert.sv
test/vectorCommitTb.sv
